// ==== common/ex_pkg.sv ====
package ex_pkg;

    localparam int XLEN     = 64;
    localparam int ILEN_IMM = 32;
    localparam int REG_AW   = 5;
    localparam int CSR_AW   = 12;

    typedef logic [XLEN-1:0] xlen_t;

    // Operand B select ------------------------------
    localparam logic [1:0] OPB_SRC2 = 2'b00;
    localparam logic [1:0] OPB_FOUR = 2'b01;
    localparam logic [1:0] OPB_IMM  = 2'b10;
    localparam logic [1:0] OPB_CSR  = 2'b11;

    // Branch codes ----------------------------------
    localparam logic [2:0] BR_NONE = 3'b000;
    localparam logic [2:0] BR_JAL  = 3'b001;
    localparam logic [2:0] BR_JALR = 3'b010;
    localparam logic [2:0] BR_EQ   = 3'b100;  // Taken on zero
    localparam logic [2:0] BR_NE   = 3'b101;
    localparam logic [2:0] BR_LT   = 3'b110;  // Taken on result bit 0
    localparam logic [2:0] BR_GE   = 3'b111;

    // ALU ops ---------------------------------------
    localparam logic [3:0] ALU_ADD   = 4'd0;
    localparam logic [3:0] ALU_SUB   = 4'd1;
    localparam logic [3:0] ALU_SLL   = 4'd2;
    localparam logic [3:0] ALU_SLT   = 4'd3;
    localparam logic [3:0] ALU_SLTU  = 4'd4;
    localparam logic [3:0] ALU_XOR   = 4'd5;
    localparam logic [3:0] ALU_SRL   = 4'd6;
    localparam logic [3:0] ALU_SRA   = 4'd7;
    localparam logic [3:0] ALU_OR    = 4'd8;
    localparam logic [3:0] ALU_AND   = 4'd9;
    localparam logic [3:0] ALU_COPYB = 4'd10;  // LUI, CSR read

    // Multiply ops, 100 to 111 are division ---------
    localparam logic [2:0] MUL_LO  = 3'b000;
    localparam logic [2:0] MUL_H   = 3'b001;
    localparam logic [2:0] MUL_HSU = 3'b010;
    localparam logic [2:0] MUL_HU  = 3'b011;

    typedef struct packed {
        logic       mul_sel;
        logic       word;
        logic [3:0] op;
    } alu_view_t;

    typedef struct packed {
        logic       mul_sel;
        logic       word;
        logic       rsvd;
        logic [2:0] op;
    } mul_view_t;

    typedef union packed {
        alu_view_t alu_v;
        mul_view_t mul_v;
    } alu_ctrl_u;

endpackage

// ==== execute/ex_latch.sv ====
module ex_latch import ex_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                block,
    input  logic                valid_in,
    input  logic                error_in,
    input  xlen_t               src1_in,
    input  xlen_t               src2_in,
    input  logic [ILEN_IMM-1:0] imm_in,
    input  xlen_t               csr_data_in,
    input  xlen_t               pc_in,
    input  logic [CSR_AW-1:0]   csr_addr_in,
    input  logic                opa_pc_in,
    input  logic [1:0]          opb_sel_in,
    input  alu_ctrl_u           alu_ctrl_in,
    input  logic [REG_AW-1:0]   rd_in,
    input  logic [2:0]          branch_in,
    input  logic [2:0]          mem_op_in,
    input  logic                mem_rd_in,
    input  logic                mem_wr_in,
    input  logic                reg_wr_in,
    input  logic                csr_in,
    input  logic                ecall_in,
    input  logic                mret_in,
    input  logic                done_in,
    output logic                valid_held,
    output xlen_t               src1,
    output xlen_t               src2,
    output xlen_t               pc,
    output xlen_t               imm_ext,
    output xlen_t               opa,
    output xlen_t               opb,
    output alu_ctrl_u           alu_ctrl,
    output logic [2:0]          branch,
    output logic [REG_AW-1:0]   rd,
    output logic [CSR_AW-1:0]   csr_addr,
    output logic [2:0]          mem_op,
    output logic                mem_rd,
    output logic                mem_wr,
    output logic                reg_wr,
    output logic                csr,
    output logic                ecall,
    output logic                mret,
    output logic                done,
    output logic                error_held
);

    logic [ILEN_IMM-1:0] imm_q;
    xlen_t               csr_data_q;
    logic                opa_pc_q;
    logic [1:0]          opb_sel_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_held <= 1'b0;
        end else if (!block) begin
            valid_held <= valid_in;
        end
    end

    // Stage register ----------------------------------
    always_ff @(posedge clk) begin
        if (!block) begin  // Hold everything while blocked
            error_held <= error_in;
            src1       <= src1_in;
            src2       <= src2_in;
            imm_q      <= imm_in;
            csr_data_q <= csr_data_in;
            pc         <= pc_in;
            csr_addr   <= csr_addr_in;
            opa_pc_q   <= opa_pc_in;
            opb_sel_q  <= opb_sel_in;
            alu_ctrl   <= alu_ctrl_in;
            rd         <= rd_in;
            branch     <= branch_in;
            mem_op     <= mem_op_in;
            mem_rd     <= mem_rd_in;
            mem_wr     <= mem_wr_in;
            reg_wr     <= reg_wr_in;
            csr        <= csr_in;
            ecall      <= ecall_in;
            mret       <= mret_in;
            done       <= done_in;
        end
    end

    assign imm_ext = {{(XLEN-ILEN_IMM){imm_q[ILEN_IMM-1]}}, imm_q};

    // Operand select ----------------------------------
    assign opa = opa_pc_q ? pc : src1;

    always_comb begin
        unique case (opb_sel_q)
            OPB_SRC2: opb = src2;
            OPB_FOUR: opb = xlen_t'(4);
            OPB_IMM:  opb = imm_ext;
            default:  opb = csr_data_q;  // OPB_CSR
        endcase
    end

endmodule

// ==== execute/alu.sv ====
module alu import ex_pkg::*; (
    input  xlen_t     opa,
    input  xlen_t     opb,
    input  alu_ctrl_u ctrl,
    output xlen_t     result,
    output logic      zero
);

    xlen_t       res_full;
    logic [31:0] res_word;
    logic [31:0] a32;
    logic [31:0] b32;

    assign a32 = opa[31:0];
    assign b32 = opb[31:0];

    // Full width ------------------------------------
    always_comb begin
        unique case (ctrl.alu_v.op)
            ALU_ADD:   res_full = opa + opb;
            ALU_SUB:   res_full = opa - opb;
            ALU_SLL:   res_full = opa << opb[5:0];
            ALU_SLT:   res_full = {{(XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
            ALU_SLTU:  res_full = {{(XLEN-1){1'b0}}, opa < opb};
            ALU_XOR:   res_full = opa ^ opb;
            ALU_SRL:   res_full = opa >> opb[5:0];
            ALU_SRA:   res_full = $signed(opa) >>> opb[5:0];
            ALU_OR:    res_full = opa | opb;
            ALU_AND:   res_full = opa & opb;
            ALU_COPYB: res_full = opb;
            default:   res_full = '0;
        endcase
    end

    // Word forms, 5-bit shift amount
    always_comb begin
        unique case (ctrl.alu_v.op)
            ALU_ADD: res_word = a32 + b32;
            ALU_SUB: res_word = a32 - b32;
            ALU_SLL: res_word = a32 << b32[4:0];
            ALU_SRL: res_word = a32 >> b32[4:0];
            ALU_SRA: res_word = $signed(a32) >>> b32[4:0];
            default: res_word = res_full[31:0];
        endcase
    end

    assign result = ctrl.alu_v.word ? {{(XLEN-32){res_word[31]}}, res_word} : res_full;
    assign zero   = (result == '0);

endmodule

// ==== execute/mul_unit.sv ====
module mul_unit import ex_pkg::*; (
    input  xlen_t     src1,
    input  xlen_t     src2,
    input  alu_ctrl_u ctrl,
    output xlen_t     product,
    output logic      illegal
);

    logic [2:0]        op;
    logic              a_signed;
    logic              b_signed;
    logic [2*XLEN-1:0] a_ext;
    logic [2*XLEN-1:0] b_ext;
    logic [2*XLEN-1:0] prod_full;

    assign op       = ctrl.mul_v.op;
    assign a_signed = (op == MUL_H) || (op == MUL_HSU);
    assign b_signed = (op == MUL_H);

    // Extend to 128 bits, low half of the wide product is exact
    assign a_ext = {{XLEN{a_signed & src1[XLEN-1]}}, src1};
    assign b_ext = {{XLEN{b_signed & src2[XLEN-1]}}, src2};

    assign prod_full = a_ext * b_ext;

    always_comb begin
        if (ctrl.mul_v.word) begin
            // Low 32 bits only depend on the low words
            product = {{(XLEN-32){prod_full[31]}}, prod_full[31:0]};
        end else if (op == MUL_LO) begin
            product = prod_full[XLEN-1:0];
        end else begin
            product = prod_full[2*XLEN-1:XLEN];
        end
    end

    assign illegal = op[2] | (ctrl.mul_v.word & (op != MUL_LO));  // No divider

endmodule

// ==== execute/branch_unit.sv ====
module branch_unit import ex_pkg::*; (
    input  xlen_t      pc,
    input  xlen_t      src1,
    input  xlen_t      imm_ext,
    input  logic [2:0] branch,
    input  logic       zero,
    input  logic       res_lsb,
    output xlen_t      nxtpc,
    output logic       taken
);

    xlen_t pc_imm;
    xlen_t reg_imm;

    assign pc_imm  = pc + imm_ext;
    assign reg_imm = src1 + imm_ext;

    always_comb begin
        unique case (branch)
            BR_JAL:  taken = 1'b1;
            BR_JALR: taken = 1'b1;
            BR_EQ:   taken = zero;
            BR_NE:   taken = ~zero;
            BR_LT:   taken = res_lsb;  // SLT or SLTU picked by decode
            BR_GE:   taken = ~res_lsb;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (branch == BR_JALR) begin
            nxtpc = {reg_imm[XLEN-1:1], 1'b0};
        end else if (taken) begin
            nxtpc = pc_imm;
        end else begin
            nxtpc = pc + xlen_t'(4);
        end
    end

endmodule

// ==== source/ex_commit.sv ====
module ex_commit import ex_pkg::*; (
    input  logic      valid_held,
    input  logic      raise_intr,
    input  logic      error_held,
    input  alu_ctrl_u ctrl,
    input  xlen_t     alu_result,
    input  xlen_t     product,
    input  logic      illegal,
    input  logic      taken,
    input  logic      csr,
    output logic      valid,
    output logic      error,
    output xlen_t     result,
    output logic      is_jmp
);

    // Result and error --------------------------------
    assign result = ctrl.alu_v.mul_sel ? product : alu_result;
    assign error  = error_held | (illegal & ctrl.alu_v.mul_sel);

    // Gating ------------------------------------------
    assign valid  = valid_held & ~raise_intr;
    assign is_jmp = (taken | csr) & valid_held;  // Interrupt does not mask

endmodule

// ==== source/ex_top.sv ====
module ex_top import ex_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                block,
    input  logic                raise_intr,
    input  logic                valid_in,
    input  logic                error_in,
    input  xlen_t               src1_in,
    input  xlen_t               src2_in,
    input  logic [ILEN_IMM-1:0] imm_in,
    input  xlen_t               csr_data_in,
    input  xlen_t               pc_in,
    input  logic [CSR_AW-1:0]   csr_addr_in,
    input  logic                opa_pc_in,
    input  logic [1:0]          opb_sel_in,
    input  alu_ctrl_u           alu_ctrl_in,
    input  logic [REG_AW-1:0]   rd_in,
    input  logic [2:0]          branch_in,
    input  logic [2:0]          mem_op_in,
    input  logic                mem_rd_in,
    input  logic                mem_wr_in,
    input  logic                reg_wr_in,
    input  logic                csr_in,
    input  logic                ecall_in,
    input  logic                mret_in,
    input  logic                done_in,
    output logic                valid,
    output logic                valid_held,
    output logic                error,
    output xlen_t               result,
    output xlen_t               nxtpc,
    output logic                is_jmp,
    output logic [REG_AW-1:0]   rd,
    output logic [CSR_AW-1:0]   csr_addr,
    output logic [2:0]          mem_op,
    output logic                mem_rd,
    output logic                mem_wr,
    output logic                reg_wr,
    output logic                csr,
    output logic                ecall,
    output logic                mret,
    output logic                done
);

    xlen_t      src1;
    xlen_t      src2;
    xlen_t      pc;
    xlen_t      imm_ext;
    xlen_t      opa;
    xlen_t      opb;
    alu_ctrl_u  alu_ctrl;
    logic [2:0] branch;
    logic       error_held;
    xlen_t      alu_result;
    logic       zero;
    xlen_t      product;
    logic       illegal;
    logic       taken;

    // Input side --------------------------------------
    ex_latch u_latch (
        .clk        (clk),
        .arst_n     (arst_n),
        .block      (block),
        .valid_in   (valid_in),
        .error_in   (error_in),
        .src1_in    (src1_in),
        .src2_in    (src2_in),
        .imm_in     (imm_in),
        .csr_data_in(csr_data_in),
        .pc_in      (pc_in),
        .csr_addr_in(csr_addr_in),
        .opa_pc_in  (opa_pc_in),
        .opb_sel_in (opb_sel_in),
        .alu_ctrl_in(alu_ctrl_in),
        .rd_in      (rd_in),
        .branch_in  (branch_in),
        .mem_op_in  (mem_op_in),
        .mem_rd_in  (mem_rd_in),
        .mem_wr_in  (mem_wr_in),
        .reg_wr_in  (reg_wr_in),
        .csr_in     (csr_in),
        .ecall_in   (ecall_in),
        .mret_in    (mret_in),
        .done_in    (done_in),
        .valid_held (valid_held),
        .src1       (src1),
        .src2       (src2),
        .pc         (pc),
        .imm_ext    (imm_ext),
        .opa        (opa),
        .opb        (opb),
        .alu_ctrl   (alu_ctrl),
        .branch     (branch),
        .rd         (rd),
        .csr_addr   (csr_addr),
        .mem_op     (mem_op),
        .mem_rd     (mem_rd),
        .mem_wr     (mem_wr),
        .reg_wr     (reg_wr),
        .csr        (csr),
        .ecall      (ecall),
        .mret       (mret),
        .done       (done),
        .error_held (error_held)
    );

    // Processing --------------------------------------
    alu u_alu (
        .opa   (opa),
        .opb   (opb),
        .ctrl  (alu_ctrl),
        .result(alu_result),
        .zero  (zero)
    );

    mul_unit u_mul (
        .src1   (src1),
        .src2   (src2),
        .ctrl   (alu_ctrl),
        .product(product),
        .illegal(illegal)
    );

    branch_unit u_branch (
        .pc     (pc),
        .src1   (src1),
        .imm_ext(imm_ext),
        .branch (branch),
        .zero   (zero),
        .res_lsb(alu_result[0]),
        .nxtpc  (nxtpc),
        .taken  (taken)
    );

    // Output side -------------------------------------
    ex_commit u_commit (
        .valid_held(valid_held),
        .raise_intr(raise_intr),
        .error_held(error_held),
        .ctrl      (alu_ctrl),
        .alu_result(alu_result),
        .product   (product),
        .illegal   (illegal),
        .taken     (taken),
        .csr       (csr),
        .valid     (valid),
        .error     (error),
        .result    (result),
        .is_jmp    (is_jmp)
    );

endmodule

// ==== test/ex_tb.sv ====
module ex_tb import ex_pkg::*;;

    typedef struct packed {
        logic [5:0]  ctrl;  // mul_sel, word, op
        logic        opa_pc;
        logic [1:0]  opb_sel;
        logic [2:0]  br;
        logic        err_in;
        logic        csr;
        xlen_t       s1;
        xlen_t       s2;
        logic [31:0] imm;
        xlen_t       res;
        xlen_t       npc;
        logic        jmp;
        logic        err;
    } entry_t;

    localparam xlen_t PC0  = 64'h1000;
    localparam xlen_t NXT  = 64'h1004;
    localparam xlen_t TGT  = 64'h1040;
    localparam xlen_t CSRD = 64'hc5;
    localparam xlen_t ALL1 = -64'd1;
    localparam xlen_t MSB  = 64'h8000_0000_0000_0000;
    localparam xlen_t W_NEG = 64'hffff_ffff_8000_0000;

    logic clk;
    logic arst_n;
    logic block;
    logic raise_intr;
    logic valid_in;
    logic error_in;
    xlen_t src1_in;
    xlen_t src2_in;
    logic [ILEN_IMM-1:0] imm_in;
    xlen_t csr_data_in;
    xlen_t pc_in;
    logic [CSR_AW-1:0] csr_addr_in;
    logic opa_pc_in;
    logic [1:0] opb_sel_in;
    alu_ctrl_u alu_ctrl_in;
    logic [REG_AW-1:0] rd_in;
    logic [2:0] branch_in;
    logic [2:0] mem_op_in;
    logic mem_rd_in;
    logic mem_wr_in;
    logic reg_wr_in;
    logic csr_in;
    logic ecall_in;
    logic mret_in;
    logic done_in;
    logic valid;
    logic valid_held;
    logic error;
    xlen_t result;
    xlen_t nxtpc;
    logic is_jmp;
    logic [REG_AW-1:0] rd;
    logic [CSR_AW-1:0] csr_addr;
    logic [2:0] mem_op;
    logic mem_rd;
    logic mem_wr;
    logic reg_wr;
    logic csr;
    logic ecall;
    logic mret;
    logic done;

    entry_t tbl[$];
    integer seed = 32'h1f41;
    logic [25:0] side;  // rd, csr_addr, mem_op, mem_rd, mem_wr, reg_wr, ecall, mret, done

    ex_top u_dut (
        .clk(clk), .arst_n(arst_n), .block(block), .raise_intr(raise_intr),
        .valid_in(valid_in), .error_in(error_in), .src1_in(src1_in),
        .src2_in(src2_in), .imm_in(imm_in), .csr_data_in(csr_data_in),
        .pc_in(pc_in), .csr_addr_in(csr_addr_in), .opa_pc_in(opa_pc_in),
        .opb_sel_in(opb_sel_in), .alu_ctrl_in(alu_ctrl_in), .rd_in(rd_in),
        .branch_in(branch_in), .mem_op_in(mem_op_in), .mem_rd_in(mem_rd_in),
        .mem_wr_in(mem_wr_in), .reg_wr_in(reg_wr_in), .csr_in(csr_in),
        .ecall_in(ecall_in), .mret_in(mret_in), .done_in(done_in),
        .valid(valid), .valid_held(valid_held),
        .error(error), .result(result), .nxtpc(nxtpc), .is_jmp(is_jmp),
        .rd(rd), .csr_addr(csr_addr), .mem_op(mem_op), .mem_rd(mem_rd),
        .mem_wr(mem_wr), .reg_wr(reg_wr), .csr(csr), .ecall(ecall),
        .mret(mret), .done(done)
    );

    always #20 clk = ~clk;

    initial begin
        arst_n = 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
    end

    // Checks ------------------------------------------
    task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_field(input string name, input logic [CSR_AW-1:0] exp,
                               input logic [CSR_AW-1:0] act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_pass(input logic [25:0] fields);
        check_field("rd", CSR_AW'(fields[25:21]), CSR_AW'(rd));
        check_field("csr_addr", fields[20:9], csr_addr);
        check_field("mem_op", CSR_AW'(fields[8:6]), CSR_AW'(mem_op));
        check_bit("mem_rd", fields[5], mem_rd);
        check_bit("mem_wr", fields[4], mem_wr);
        check_bit("reg_wr", fields[3], reg_wr);
        check_bit("ecall", fields[2], ecall);
        check_bit("mret", fields[1], mret);
        check_bit("done", fields[0], done);
    endtask

    task automatic add(input logic [5:0] ctrl, input logic opa_pc, input logic [1:0] opb_sel,
                       input logic [2:0] br, input logic err_in, input logic csr_f,
                       input xlen_t s1, input xlen_t s2, input logic [31:0] imm,
                       input xlen_t res, input xlen_t npc, input logic jmp, input logic err);
        entry_t e;
        e = '{ctrl, opa_pc, opb_sel, br, err_in, csr_f, s1, s2, imm, res, npc, jmp, err};
        tbl.push_back(e);
    endtask

    task automatic drive_entry(input entry_t e, input logic vin, input logic [25:0] fields);
        valid_in    <= vin;
        error_in    <= e.err_in;
        src1_in     <= e.s1;
        src2_in     <= e.s2;
        imm_in      <= e.imm;
        pc_in       <= PC0;
        opa_pc_in   <= e.opa_pc;
        opb_sel_in  <= e.opb_sel;
        alu_ctrl_in <= e.ctrl;
        branch_in   <= e.br;
        csr_in      <= e.csr;
        {rd_in, csr_addr_in, mem_op_in, mem_rd_in, mem_wr_in, reg_wr_in, ecall_in, mret_in,
         done_in} <= fields;
    endtask

    // Drive on one edge, captured on the next, checked mid-cycle
    task automatic apply_check(input entry_t e);
        @(posedge clk);
        side = 26'($random(seed));
        drive_entry(e, 1'b1, side);
        @(posedge clk);
        @(negedge clk);
        check_word("result", e.res, result);
        check_word("nxtpc", e.npc, nxtpc);
        check_bit("is_jmp", e.jmp, is_jmp);
        check_bit("error", e.err, error);
        check_bit("valid", 1'b1, valid);
        check_bit("valid_held", 1'b1, valid_held);
        check_bit("csr", e.csr, csr);
        check_pass(side);
    endtask

    function automatic xlen_t model_alu(input logic [3:0] op, input xlen_t a, input xlen_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            ALU_SLTU: return (a < b) ? 64'd1 : 64'd0;
            ALU_XOR:  return a ^ b;
            ALU_OR:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    initial begin
        entry_t e;
        logic [3:0] ops [7];
        int cnt;
        int idx;
        clk = 1'b0;
        block = 1'b0;
        raise_intr = 1'b0;
        csr_data_in = CSRD;
        e = '0;
        e.br = BR_JAL;
        e.csr = 1'b1;
        drive_entry(e, 1'b1, '0);  // Valid jump waiting behind reset
        ops = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND};

        // ALU, operand select
        add(6'h00, 0, OPB_SRC2, BR_NONE, 0, 0, 5, 7, 0, 12, NXT, 0, 0);
        add(6'h01, 0, OPB_SRC2, BR_NONE, 0, 0, 5, 7, 0, -64'd2, NXT, 0, 0);
        add(6'h02, 0, OPB_IMM, BR_NONE, 0, 0, 1, 0, 4, 16, NXT, 0, 0);
        add(6'h03, 0, OPB_SRC2, BR_NONE, 0, 0, ALL1, 1, 0, 1, NXT, 0, 0);
        add(6'h04, 0, OPB_SRC2, BR_NONE, 0, 0, ALL1, 1, 0, 0, NXT, 0, 0);
        add(6'h05, 0, OPB_SRC2, BR_NONE, 0, 0, 'hf0, 'hff, 0, 'h0f, NXT, 0, 0);
        add(6'h06, 0, OPB_SRC2, BR_NONE, 0, 0, MSB, 63, 0, 1, NXT, 0, 0);
        add(6'h07, 0, OPB_SRC2, BR_NONE, 0, 0, MSB, 63, 0, ALL1, NXT, 0, 0);
        add(6'h08, 0, OPB_SRC2, BR_NONE, 0, 0, 'hf0, 'h0f, 0, 'hff, NXT, 0, 0);
        add(6'h09, 0, OPB_SRC2, BR_NONE, 0, 0, 'hf0, 'h3c, 0, 'h30, NXT, 0, 0);
        add(6'h0a, 0, OPB_CSR, BR_NONE, 0, 0, 0, 0, 0, CSRD, NXT, 0, 0);
        add(6'h00, 1, OPB_FOUR, BR_NONE, 0, 0, 0, 0, 0, NXT, NXT, 0, 0);
        add(6'h00, 1, OPB_IMM, BR_NONE, 0, 0, 0, 0, 'h10, 'h1010, NXT, 0, 0);
        // Word forms
        add(6'h10, 0, OPB_SRC2, BR_NONE, 0, 0, 'h7fff_ffff, 1, 0, W_NEG, NXT, 0, 0);
        add(6'h11, 0, OPB_SRC2, BR_NONE, 0, 0, 0, 1, 0, ALL1, NXT, 0, 0);
        add(6'h12, 0, OPB_SRC2, BR_NONE, 0, 0, 1, 31, 0, W_NEG, NXT, 0, 0);
        add(6'h16, 0, OPB_SRC2, BR_NONE, 0, 0, W_NEG, 31, 0, 1, NXT, 0, 0);
        add(6'h17, 0, OPB_SRC2, BR_NONE, 0, 0, W_NEG, 31, 0, ALL1, NXT, 0, 0);
        // Multiplies and illegal encodings
        add(6'h20, 0, OPB_SRC2, BR_NONE, 0, 0, 3, -64'd2, 0, -64'd6, NXT, 0, 0);
        add(6'h21, 0, OPB_SRC2, BR_NONE, 0, 0, 2, ALL1, 0, ALL1, NXT, 0, 0);
        add(6'h22, 0, OPB_SRC2, BR_NONE, 0, 0, 2, ALL1, 0, 1, NXT, 0, 0);
        add(6'h23, 0, OPB_SRC2, BR_NONE, 0, 0, ALL1, 2, 0, 1, NXT, 0, 0);
        add(6'h30, 0, OPB_SRC2, BR_NONE, 0, 0, 'h1_0000_0003, 'h5_7fff_ffff, 0,
            'h7fff_fffd, NXT, 0, 0);
        add(6'h24, 0, OPB_SRC2, BR_NONE, 0, 0, 0, 0, 0, 0, NXT, 0, 1);
        add(6'h31, 0, OPB_SRC2, BR_NONE, 0, 0, 0, 0, 0, 0, NXT, 0, 1);
        add(6'h00, 0, OPB_SRC2, BR_NONE, 1, 0, 0, 0, 0, 0, NXT, 0, 1);
        // Branches and jumps
        add(6'h00, 1, OPB_FOUR, BR_JAL, 0, 0, 0, 0, 'h40, NXT, TGT, 1, 0);
        add(6'h00, 1, OPB_FOUR, BR_JALR, 0, 0, 'h2001, 0, 'h10, NXT, 'h2010, 1, 0);
        add(6'h01, 0, OPB_SRC2, BR_EQ, 0, 0, 5, 5, 'h40, 0, TGT, 1, 0);
        add(6'h01, 0, OPB_SRC2, BR_EQ, 0, 0, 5, 6, 'h40, ALL1, NXT, 0, 0);
        add(6'h01, 0, OPB_SRC2, BR_NE, 0, 0, 5, 6, 'h40, ALL1, TGT, 1, 0);
        add(6'h03, 0, OPB_SRC2, BR_LT, 0, 0, ALL1, 1, 'h40, 1, TGT, 1, 0);
        add(6'h03, 0, OPB_SRC2, BR_GE, 0, 0, ALL1, 1, 'h40, 1, NXT, 0, 0);
        add(6'h04, 0, OPB_SRC2, BR_LT, 0, 0, ALL1, 1, 'h40, 0, NXT, 0, 0);
        add(6'h04, 0, OPB_SRC2, BR_GE, 0, 0, ALL1, 1, 'h40, 0, TGT, 1, 0);
        add(6'h0a, 0, OPB_CSR, BR_NONE, 0, 1, 0, 0, 0, CSRD, NXT, 1, 0);

        cnt = 0;
        while (arst_n !== 1'b1) begin
            @(negedge clk);
            cnt++;
            if (cnt > 50) begin
                $display("timeout waiting for reset release");
                $display("Simulation finished: FAIL");
                $fatal(1);
            end
        end
        check_bit("valid", 1'b0, valid);
        check_bit("is_jmp", 1'b0, is_jmp);

        foreach (tbl[i]) apply_check(tbl[i]);

        // Random operands against the model
        for (int n = 0; n < 32; n++) begin
            e = '0;
            e.s1 = {$random(seed), $random(seed)};
            e.s2 = {$random(seed), $random(seed)};
            idx = $unsigned($random(seed)) % 8;
            if (idx == 7) begin
                e.ctrl = {2'b10, 1'b0, MUL_LO};
                e.res  = e.s1 * e.s2;
            end else begin
                e.ctrl = {2'b00, ops[idx]};
                e.res  = model_alu(ops[idx], e.s1, e.s2);
            end
            e.opb_sel = OPB_SRC2;
            e.npc = NXT;
            apply_check(e);
        end

        // Block hold, then interrupt masking ------------
        apply_check(tbl[26]);
        @(posedge clk);
        block <= 1'b1;
        drive_entry(tbl[0], 1'b0, ~side);
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_word("result", NXT, result);
        check_word("nxtpc", TGT, nxtpc);
        check_bit("valid", 1'b1, valid);
        check_bit("is_jmp", 1'b1, is_jmp);
        check_bit("csr", 1'b0, csr);
        check_pass(side);
        @(posedge clk);
        raise_intr <= 1'b1;
        @(negedge clk);
        check_bit("valid", 1'b0, valid);
        check_bit("valid_held", 1'b1, valid_held);
        check_bit("is_jmp", 1'b1, is_jmp);
        @(posedge clk);
        block <= 1'b0;
        raise_intr <= 1'b0;
        drive_entry(tbl[26], 1'b0, side);  // Jump without valid

        cnt = 0;
        while (valid_held) begin
            @(negedge clk);
            cnt++;
            if (cnt > 10) begin
                $display("timeout waiting for stage to drain");
                $display("Simulation finished: FAIL");
                $fatal(1);
            end
        end
        check_bit("valid", 1'b0, valid);
        check_bit("is_jmp", 1'b0, is_jmp);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== files.f ====
common/ex_pkg.sv
execute/ex_latch.sv
execute/alu.sv
execute/mul_unit.sv
execute/branch_unit.sv
source/ex_commit.sv
source/ex_top.sv
test/ex_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module ex_tb -f files.f -o ex_sim \
    && ./obj_dir/ex_sim > sim.log 2>&1 \
    || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0
